// File: mfp.f
+incdir+.
mfp_pkg.sv
mfp_timer.sv
mfp_irq_ctrl.sv
mfp_tx_fifo.sv
mfp.sv
mfp_tb.sv

// File: mfp_tb.sv
// mfp testbench
`timescale 1ns/1ps
`include "mfp_settings.svh"

module mfp_tb;
	import mfp_pkg::*;

	// fifo keeps one slot free
	localparam int FIFO_SLOTS = (1 << `MFP_FIFO_ADDR_BITS) - 1;

	logic       clk;
	logic       reset;
	mfp_byte_t  din_i;
	logic       sel_i;
	mfp_addr_t  addr_i;
	logic       ds_i;
	logic       rw_i;
	logic       iack_i;
	mfp_byte_t  dout_o;
	logic       irq_o;
	logic       serial_available_o;
	mfp_byte_t  serial_data_o;
	logic       serial_strobe_i;
	logic       clk_ext_i;
	logic [1:0] t_i;
	mfp_byte_t  gpip_i;

	// register shadow and tx byte queue
	mfp_byte_t    sh_gpip;
	mfp_byte_t    sh_aer;
	mfp_byte_t    sh_ddr;
	mfp_byte_t    sh_vr;
	mfp_irq_vec_t sh_ier;
	mfp_irq_vec_t sh_ipr;
	mfp_irq_vec_t sh_isr;
	mfp_irq_vec_t sh_imr;
	mfp_byte_t    fifo_q[$];
	integer       seed;
	mfp_byte_t    vec;

	mfp i_dut (
		.clk                (clk),
		.reset              (reset),
		.din_i              (din_i),
		.sel_i              (sel_i),
		.addr_i             (addr_i),
		.ds_i               (ds_i),
		.rw_i               (rw_i),
		.iack_i             (iack_i),
		.dout_o             (dout_o),
		.irq_o              (irq_o),
		.serial_available_o (serial_available_o),
		.serial_data_o      (serial_data_o),
		.serial_strobe_i    (serial_strobe_i),
		.clk_ext_i          (clk_ext_i),
		.t_i                (t_i),
		.gpip_i             (gpip_i)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// external timer clock with a half period of 3 clk
	initial begin
		clk_ext_i = 1'b0;
		forever begin
			repeat (3) @(posedge clk);
			#2 clk_ext_i = ~clk_ext_i;
		end
	end

	// expected read value from the shadow
	function automatic mfp_byte_t expected_read(input mfp_addr_t a);
		mfp_byte_t port;
		case (a)
			`MFP_A_GPIP: begin
				// output bits read the register, input bits the pins
				for (int k = 0; k < 8; k++)
					port[k] = sh_ddr[k] ? sh_gpip[k] : gpip_i[k];
				return port;
			end
			`MFP_A_AER:  return sh_aer;
			`MFP_A_DDR:  return sh_ddr;
			`MFP_A_IERA: return sh_ier[15:8];
			`MFP_A_IERB: return sh_ier[7:0];
			`MFP_A_IPRA: return sh_ipr[15:8];
			`MFP_A_IPRB: return sh_ipr[7:0];
			`MFP_A_ISRA: return sh_isr[15:8];
			`MFP_A_ISRB: return sh_isr[7:0];
			`MFP_A_IMRA: return sh_imr[15:8];
			`MFP_A_IMRB: return sh_imr[7:0];
			`MFP_A_VR:   return sh_vr;
			// bit 7 set while there is room
			`MFP_A_TSR:  return {fifo_q.size() < FIFO_SLOTS, 7'b0000000};
			default:     return 8'h00;
		endcase
	endfunction

	task automatic stop_with_failure();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check(input logic [15:0] actual, input logic [15:0] expected,
		input string name);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name,
				actual, expected);
			stop_with_failure();
		end
	endtask

	// bus write with the shadow following the register rules
	task automatic write_reg(input mfp_addr_t addr, input mfp_byte_t data);
		@(posedge clk);
		#2;
		sel_i  = 1'b1;
		ds_i   = 1'b0;
		rw_i   = 1'b0;
		addr_i = addr;
		din_i  = data;
		@(posedge clk);
		#2;
		sel_i = 1'b0;
		ds_i  = 1'b1;
		rw_i  = 1'b1;
		case (addr)
			`MFP_A_GPIP: sh_gpip = data;
			`MFP_A_AER:  sh_aer = data;
			`MFP_A_DDR:  sh_ddr = data;
			`MFP_A_IERA: begin
				sh_ier[15:8] = data;
				sh_ipr[15:8] = sh_ipr[15:8] & data;
			end
			`MFP_A_IERB: begin
				sh_ier[7:0] = data;
				sh_ipr[7:0] = sh_ipr[7:0] & data;
			end
			`MFP_A_IPRA: sh_ipr[15:8] = sh_ipr[15:8] & data;
			`MFP_A_IPRB: sh_ipr[7:0] = sh_ipr[7:0] & data;
			`MFP_A_ISRA: sh_isr[15:8] = sh_isr[15:8] & data;
			`MFP_A_ISRB: sh_isr[7:0] = sh_isr[7:0] & data;
			`MFP_A_IMRA: sh_imr[15:8] = data;
			`MFP_A_IMRB: sh_imr[7:0] = data;
			`MFP_A_VR:   sh_vr = data;
			`MFP_A_UDR: begin
				if (fifo_q.size() < FIFO_SLOTS)
					fifo_q.push_back(data);
			end
			default: ;
		endcase
	endtask

	// read is combinational so sample mid cycle
	task automatic read_reg(input mfp_addr_t addr, output mfp_byte_t data);
		@(posedge clk);
		#2;
		sel_i  = 1'b1;
		ds_i   = 1'b0;
		rw_i   = 1'b1;
		addr_i = addr;
		@(negedge clk);
		data = dout_o;
		@(posedge clk);
		#2;
		sel_i = 1'b0;
		ds_i  = 1'b1;
	endtask

	task automatic verify_reg(input mfp_addr_t addr, input string name);
		mfp_byte_t data;
		read_reg(addr, data);
		check(data, expected_read(addr), name);
	endtask

	task automatic wait_irq(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (irq_o !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (irq_o !== level) begin
			$display("timeout: irq_o never went to %0d after %s", level, what);
			stop_with_failure();
		end
	endtask

	// vector shows while iack is high and the source clears a cycle later
	task automatic acknowledge(output mfp_byte_t v);
		@(posedge clk);
		#2 iack_i = 1'b1;
		@(negedge clk);
		v = dout_o;
		@(posedge clk);
		#2 iack_i = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// take the head byte and then strobe
	task automatic pull_byte();
		int n;
		n = 0;
		@(negedge clk);
		while (!serial_available_o && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (!serial_available_o) begin
			$display("timeout: serial_available_o never rose with bytes queued");
			stop_with_failure();
		end
		check(serial_data_o, fifo_q.pop_front(), "serial_data_o");
		@(posedge clk);
		#2 serial_strobe_i = 1'b1;
		@(posedge clk);
		#2 serial_strobe_i = 1'b0;
		// read pointer moves two cycles after the strobe edge
		repeat (2) @(posedge clk);
	endtask

	initial begin
		seed = 32'h7cc71109;
		reset = 1'b1;
		din_i = '0;
		sel_i = 1'b0;
		addr_i = '0;
		ds_i = 1'b1;
		rw_i = 1'b1;
		iack_i = 1'b0;
		serial_strobe_i = 1'b0;
		t_i = 2'b00;
		gpip_i = 8'hff;
		{sh_gpip, sh_aer, sh_ddr, sh_vr} = '0;
		{sh_ier, sh_ipr, sh_isr, sh_imr} = '0;
		repeat (5) @(posedge clk);
		#2 reset = 1'b0;
		@(negedge clk);
		check(irq_o, 1'b0, "irq_o");
		check(serial_available_o, 1'b0, "serial_available_o");
		check(dout_o, 8'h00, "dout_o");

		// register readback with random data
		@(posedge clk);
		#2 gpip_i = $random(seed);
		write_reg(`MFP_A_GPIP, $random(seed));
		write_reg(`MFP_A_AER, $random(seed));
		verify_reg(`MFP_A_AER, "aer");
		write_reg(`MFP_A_DDR, $random(seed));
		verify_reg(`MFP_A_DDR, "ddr");
		verify_reg(`MFP_A_GPIP, "gpip");
		write_reg(`MFP_A_VR, $random(seed));
		verify_reg(`MFP_A_VR, "vr");
		write_reg(`MFP_A_IERA, $random(seed));
		verify_reg(`MFP_A_IERA, "iera");
		write_reg(`MFP_A_IERB, $random(seed));
		verify_reg(`MFP_A_IERB, "ierb");
		write_reg(`MFP_A_IMRA, $random(seed));
		verify_reg(`MFP_A_IMRA, "imra");
		write_reg(`MFP_A_IMRB, $random(seed));
		verify_reg(`MFP_A_IMRB, "imrb");
		// quiet pins and let stray edges settle before clearing all
		gpip_i = 8'hff;
		write_reg(`MFP_A_AER, 8'h00);
		repeat (6) @(posedge clk);
		write_reg(`MFP_A_IERA, 8'h00);
		write_reg(`MFP_A_IERB, 8'h00);
		write_reg(`MFP_A_IMRA, 8'h00);
		write_reg(`MFP_A_IMRB, 8'h00);
		verify_reg(`MFP_A_IPRA, "ipra");
		verify_reg(`MFP_A_IPRB, "iprb");

		// timer a on source 13 with data 3 and prescale 4
		write_reg(`MFP_A_IERA, 8'h20);
		write_reg(`MFP_A_IMRA, 8'h20);
		write_reg(`MFP_A_TADR, 8'd3);
		write_reg(`MFP_A_TACR, 8'h01);
		wait_irq(1'b1, 300, "starting timer a");
		sh_ipr[`MFP_IRQ_TA] = 1'b1;
		verify_reg(`MFP_A_IPRA, "ipra");
		write_reg(`MFP_A_TACR, 8'h00);
		write_reg(`MFP_A_IPRA, 8'h00);
		@(negedge clk);
		check(irq_o, 1'b0, "irq_o");
		verify_reg(`MFP_A_IPRA, "ipra");
		// timer d on source 4
		write_reg(`MFP_A_IERB, 8'h10);
		write_reg(`MFP_A_IMRB, 8'h10);
		write_reg(`MFP_A_TDDR, 8'd3);
		write_reg(`MFP_A_TCDCR, 8'h01);
		wait_irq(1'b1, 300, "starting timer d");
		sh_ipr[`MFP_IRQ_TD] = 1'b1;
		verify_reg(`MFP_A_IPRB, "iprb");
		write_reg(`MFP_A_TCDCR, 8'h00);
		write_reg(`MFP_A_IPRB, 8'h00);
		@(negedge clk);
		check(irq_o, 1'b0, "irq_o");

		// gpip 3 and 7 together with S set
		write_reg(`MFP_A_VR, 8'h48);
		write_reg(`MFP_A_IERA, 8'h80);
		write_reg(`MFP_A_IMRA, 8'h80);
		write_reg(`MFP_A_IERB, 8'h08);
		write_reg(`MFP_A_IMRB, 8'h08);
		@(posedge clk);
		#2 gpip_i = 8'h77;
		wait_irq(1'b1, 20, "falling edges on gpip 3 and 7");
		sh_ipr[`MFP_IRQ_GP7] = 1'b1;
		sh_ipr[`MFP_IRQ_GP3] = 1'b1;
		verify_reg(`MFP_A_IPRA, "ipra");
		verify_reg(`MFP_A_IPRB, "iprb");
		acknowledge(vec);
		check(vec, {sh_vr[7:4], `MFP_IRQ_GP7}, "vector");
		sh_ipr[`MFP_IRQ_GP7] = 1'b0;
		sh_isr[`MFP_IRQ_GP7] = 1'b1;
		verify_reg(`MFP_A_IPRA, "ipra");
		verify_reg(`MFP_A_ISRA, "isra");
		// source 15 in service blocks source 3
		repeat (4) begin
			@(negedge clk);
			check(irq_o, 1'b0, "irq_o");
		end
		write_reg(`MFP_A_ISRA, 8'h00);
		wait_irq(1'b1, 10, "clearing in-service bit 15");
		acknowledge(vec);
		check(vec, {sh_vr[7:4], `MFP_IRQ_GP3}, "vector");
		sh_ipr[`MFP_IRQ_GP3] = 1'b0;
		sh_isr[`MFP_IRQ_GP3] = 1'b1;
		verify_reg(`MFP_A_IPRB, "iprb");
		verify_reg(`MFP_A_ISRB, "isrb");
		write_reg(`MFP_A_ISRB, 8'h00);

		// pending source dropped by its enable write
		gpip_i = 8'hff;
		repeat (5) @(posedge clk);
		#2 gpip_i = 8'hf7;
		wait_irq(1'b1, 20, "falling edge on gpip 3");
		sh_ipr[`MFP_IRQ_GP3] = 1'b1;
		verify_reg(`MFP_A_IPRB, "iprb");
		write_reg(`MFP_A_IERB, 8'h00);
		@(negedge clk);
		check(irq_o, 1'b0, "irq_o");
		verify_reg(`MFP_A_IPRB, "iprb");
		verify_reg(`MFP_A_IERB, "ierb");

		// tx fifo order and then fill and drain
		repeat (5)
			write_reg(`MFP_A_UDR, $random(seed));
		repeat (5)
			pull_byte();
		@(negedge clk);
		check(serial_available_o, 1'b0, "serial_available_o");
		repeat (FIFO_SLOTS)
			write_reg(`MFP_A_UDR, $random(seed));
		verify_reg(`MFP_A_TSR, "tsr");
		pull_byte();
		verify_reg(`MFP_A_TSR, "tsr");
		while (fifo_q.size() > 0)
			pull_byte();
		@(negedge clk);
		check(serial_available_o, 1'b0, "serial_available_o");

		$display("Verification passed");
		$finish;
	end

endmodule

// File: mfp.sv
// mfp top level
`timescale 1ns/1ps
`include "mfp_settings.svh"

module mfp (
	input  logic               clk,
	input  logic               reset,
	input  mfp_pkg::mfp_byte_t din_i,
	input  logic               sel_i,
	input  mfp_pkg::mfp_addr_t addr_i,
	input  logic               ds_i,
	input  logic               rw_i,
	input  logic               iack_i,
	output mfp_pkg::mfp_byte_t dout_o,
	output logic               irq_o,
	output logic               serial_available_o,
	output mfp_pkg::mfp_byte_t serial_data_o,
	input  logic               serial_strobe_i,
	input  logic               clk_ext_i,
	input  logic [1:0]         t_i,
	input  mfp_pkg::mfp_byte_t gpip_i
);
	import mfp_pkg::*;

	logic          bus_wr;
	logic          bus_rd;
	mfp_byte_t     gpip;
	mfp_byte_t     aer;
	mfp_byte_t     ddr;
	mfp_byte_t     gpip_rd;
	mfp_byte_t     ti_mask;
	mfp_byte_t     ti_val;
	mfp_byte_t     gp_s1;
	mfp_byte_t     gp_s2;
	logic [3:0]    gp_edge_q;
	mfp_tmr_ctrl_t ta_ctrl, tb_ctrl, tc_ctrl, td_ctrl;
	mfp_byte_t     ta_data, tb_data, tc_data, td_data;
	logic          ta_pulse, tb_pulse;
	logic          ta_done, tb_done, tc_done, td_done;
	mfp_irq_vec_t  irq_event;
	mfp_irq_vec_t  ier, ipr, isr, imr;
	mfp_byte_t     vr;
	mfp_byte_t     vector;
	logic          fifo_full;

	assign bus_wr = sel_i && !ds_i && !rw_i;
	assign bus_rd = sel_i && !ds_i && rw_i;

	// port registers
	always_ff @(posedge clk) begin
		if (reset) begin
			gpip <= '0;
			aer  <= '0;
			ddr  <= '0;
		end else if (bus_wr) begin
			if (addr_i == `MFP_A_GPIP)
				gpip <= din_i;
			if (addr_i == `MFP_A_AER)
				aer <= din_i;
			if (addr_i == `MFP_A_DDR)
				ddr <= din_i;
		end
	end

	// ddr bit set means output, read back the register
	assign gpip_rd = (gpip_i & ~ddr) | (gpip & ddr);

	// pulse mode timers take over gpip bits 4 and 3
	assign ti_mask = {3'b000, ta_pulse, tb_pulse, 3'b000};
	assign ti_val  = {3'b000, t_i[0], t_i[1], 3'b000};

	// two sync stages then a registered falling edge
	always_ff @(posedge clk) begin
		if (reset) begin
			gp_s1     <= '0;
			gp_s2     <= '0;
			gp_edge_q <= '0;
		end else begin
			gp_s1     <= aer ^ ((gpip_i & ~ti_mask) | (ti_val & ti_mask));
			gp_s2     <= gp_s1;
			gp_edge_q <= {gp_s2[7] & ~gp_s1[7], gp_s2[5] & ~gp_s1[5],
				gp_s2[4] & ~gp_s1[4], gp_s2[3] & ~gp_s1[3]};
		end
	end

	// map event pulses onto source numbers
	always_comb begin
		irq_event = '0;
		irq_event[`MFP_IRQ_TA]  = ta_done;
		irq_event[`MFP_IRQ_TB]  = tb_done;
		irq_event[`MFP_IRQ_TC]  = tc_done;
		irq_event[`MFP_IRQ_TD]  = td_done;
		irq_event[`MFP_IRQ_GP3] = gp_edge_q[0];
		irq_event[`MFP_IRQ_GP4] = gp_edge_q[1];
		irq_event[`MFP_IRQ_GP5] = gp_edge_q[2];
		irq_event[`MFP_IRQ_GP7] = gp_edge_q[3];
	end

	mfp_timer #(.HAS_EVENT(1)) timer_a (
		.clk          (clk),
		.reset        (reset),
		.xclk_i       (clk_ext_i),
		.ctrl_i       (din_i[4:0]),
		.ctrl_we_i    (bus_wr && addr_i == `MFP_A_TACR),
		.data_i       (din_i),
		.data_we_i    (bus_wr && addr_i == `MFP_A_TADR),
		.t_i          (t_i[0] ^ aer[4]),
		.ctrl_o       (ta_ctrl),
		.data_o       (ta_data),
		.pulse_mode_o (ta_pulse),
		.done_o       (ta_done)
	);

	mfp_timer #(.HAS_EVENT(1)) timer_b (
		.clk          (clk),
		.reset        (reset),
		.xclk_i       (clk_ext_i),
		.ctrl_i       (din_i[4:0]),
		.ctrl_we_i    (bus_wr && addr_i == `MFP_A_TBCR),
		.data_i       (din_i),
		.data_we_i    (bus_wr && addr_i == `MFP_A_TBDR),
		.t_i          (t_i[1] ^ aer[3]),
		.ctrl_o       (tb_ctrl),
		.data_o       (tb_data),
		.pulse_mode_o (tb_pulse),
		.done_o       (tb_done)
	);

	// c and d share one control register, delay mode only
	mfp_timer #(.HAS_EVENT(0)) timer_c (
		.clk          (clk),
		.reset        (reset),
		.xclk_i       (clk_ext_i),
		.ctrl_i       ({2'b00, din_i[6:4]}),
		.ctrl_we_i    (bus_wr && addr_i == `MFP_A_TCDCR),
		.data_i       (din_i),
		.data_we_i    (bus_wr && addr_i == `MFP_A_TCDR),
		.t_i          (1'b0),
		.ctrl_o       (tc_ctrl),
		.data_o       (tc_data),
		.pulse_mode_o (),
		.done_o       (tc_done)
	);

	mfp_timer #(.HAS_EVENT(0)) timer_d (
		.clk          (clk),
		.reset        (reset),
		.xclk_i       (clk_ext_i),
		.ctrl_i       ({2'b00, din_i[2:0]}),
		.ctrl_we_i    (bus_wr && addr_i == `MFP_A_TCDCR),
		.data_i       (din_i),
		.data_we_i    (bus_wr && addr_i == `MFP_A_TDDR),
		.t_i          (1'b0),
		.ctrl_o       (td_ctrl),
		.data_o       (td_data),
		.pulse_mode_o (),
		.done_o       (td_done)
	);

	// write enables are {upper half, lower half}
	mfp_irq_ctrl i_irq_ctrl (
		.clk      (clk),
		.reset    (reset),
		.din_i    (din_i),
		.ier_we_i ({bus_wr && addr_i == `MFP_A_IERA, bus_wr && addr_i == `MFP_A_IERB}),
		.ipr_we_i ({bus_wr && addr_i == `MFP_A_IPRA, bus_wr && addr_i == `MFP_A_IPRB}),
		.isr_we_i ({bus_wr && addr_i == `MFP_A_ISRA, bus_wr && addr_i == `MFP_A_ISRB}),
		.imr_we_i ({bus_wr && addr_i == `MFP_A_IMRA, bus_wr && addr_i == `MFP_A_IMRB}),
		.vr_we_i  (bus_wr && addr_i == `MFP_A_VR),
		.event_i  (irq_event),
		.iack_i   (iack_i),
		.ier_o    (ier),
		.ipr_o    (ipr),
		.isr_o    (isr),
		.imr_o    (imr),
		.vr_o     (vr),
		.vector_o (vector),
		.irq_o    (irq_o)
	);

	mfp_tx_fifo i_tx_fifo (
		.clk         (clk),
		.reset       (reset),
		.data_i      (din_i),
		.write_i     (bus_wr && addr_i == `MFP_A_UDR),
		.strobe_i    (serial_strobe_i),
		.available_o (serial_available_o),
		.data_o      (serial_data_o),
		.full_o      (fifo_full)
	);

	// cpu read mux, vector during iack
	always_comb begin
		dout_o = '0;
		if (bus_rd) begin
			case (addr_i)
				`MFP_A_GPIP:  dout_o = gpip_rd;
				`MFP_A_AER:   dout_o = aer;
				`MFP_A_DDR:   dout_o = ddr;
				`MFP_A_IERA:  dout_o = ier[15:8];
				`MFP_A_IERB:  dout_o = ier[7:0];
				`MFP_A_IPRA:  dout_o = ipr[15:8];
				`MFP_A_IPRB:  dout_o = ipr[7:0];
				`MFP_A_ISRA:  dout_o = isr[15:8];
				`MFP_A_ISRB:  dout_o = isr[7:0];
				`MFP_A_IMRA:  dout_o = imr[15:8];
				`MFP_A_IMRB:  dout_o = imr[7:0];
				`MFP_A_VR:    dout_o = vr;
				`MFP_A_TACR:  dout_o = {3'b000, ta_ctrl};
				`MFP_A_TBCR:  dout_o = {3'b000, tb_ctrl};
				`MFP_A_TCDCR: dout_o = {tc_ctrl[3:0], td_ctrl[3:0]};
				`MFP_A_TADR:  dout_o = ta_data;
				`MFP_A_TBDR:  dout_o = tb_data;
				`MFP_A_TCDR:  dout_o = tc_data;
				`MFP_A_TDDR:  dout_o = td_data;
				// buffer empty flag means room left
				`MFP_A_TSR:   dout_o = {!fifo_full, 7'b0000000};
				default:      dout_o = '0;
			endcase
		end else if (iack_i) begin
			dout_o = vector;
		end
	end

endmodule

// File: mfp_tx_fifo.sv
// uart transmit fifo toward the io controller
`timescale 1ns/1ps
`include "mfp_settings.svh"

module mfp_tx_fifo (
	input  logic               clk,
	input  logic               reset,
	input  mfp_pkg::mfp_byte_t data_i,
	input  logic               write_i,
	input  logic               strobe_i,
	output logic               available_o,
	output mfp_pkg::mfp_byte_t data_o,
	output logic               full_o
);
	import mfp_pkg::*;

	localparam int ABITS = `MFP_FIFO_ADDR_BITS;
	localparam int DEPTH = 1 << ABITS;

	mfp_byte_t        mem [DEPTH];
	logic [ABITS-1:0] wr_ptr;
	logic [ABITS-1:0] rd_ptr;
	logic             strobe_q1;
	logic             strobe_q2;
	logic             pop;

	// one slot stays free to tell full from empty
	assign available_o = (rd_ptr != wr_ptr);
	assign full_o      = (rd_ptr == wr_ptr + 1'b1);
	assign data_o      = mem[rd_ptr];

	// reader strobes after taking the head byte
	assign pop = strobe_q1 && !strobe_q2 && available_o;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			strobe_q1 <= 1'b0;
			strobe_q2 <= 1'b0;
		end else begin
			strobe_q1 <= strobe_i;
			strobe_q2 <= strobe_q1;
			// writes to a full buffer are lost
			if (write_i && !full_o)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (write_i && !full_o)
			mem[wr_ptr] <= data_i;
	end

	// cpu has to poll the status register first
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		write_i |-> !full_o)
		else $error("uart data written while tx fifo full");

endmodule

// File: mfp_irq_ctrl.sv
// interrupt controller with priority and vector
`timescale 1ns/1ps

module mfp_irq_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  mfp_pkg::mfp_byte_t    din_i,
	input  logic [1:0]            ier_we_i,
	input  logic [1:0]            ipr_we_i,
	input  logic [1:0]            isr_we_i,
	input  logic [1:0]            imr_we_i,
	input  logic                  vr_we_i,
	input  mfp_pkg::mfp_irq_vec_t event_i,
	input  logic                  iack_i,
	output mfp_pkg::mfp_irq_vec_t ier_o,
	output mfp_pkg::mfp_irq_vec_t ipr_o,
	output mfp_pkg::mfp_irq_vec_t isr_o,
	output mfp_pkg::mfp_irq_vec_t imr_o,
	output mfp_pkg::mfp_byte_t    vr_o,
	output mfp_pkg::mfp_byte_t    vector_o,
	output logic                  irq_o
);
	import mfp_pkg::*;

	mfp_irq_vec_t ier;
	mfp_irq_vec_t ipr;
	mfp_irq_vec_t isr;
	mfp_irq_vec_t imr;
	mfp_byte_t    vr;
	mfp_irq_vec_t ipr_nxt;
	mfp_irq_vec_t isr_nxt;
	mfp_irq_vec_t pend_map;
	mfp_irq_vec_t active_map;
	mfp_irq_num_t hi_pend;
	mfp_irq_num_t hi_active;
	mfp_byte_t    vec_q;
	logic         vec_valid_q;
	logic         iack_q1;
	logic         iack_q2;
	logic         ack_fire;

	// number of the highest set bit or 0 when empty
	function automatic mfp_irq_num_t highest(input mfp_irq_vec_t map);
		mfp_irq_num_t n;
		n = '0;
		for (int k = 0; k < 16; k++) begin
			if (map[k])
				n = mfp_irq_num_t'(k);
		end
		return n;
	endfunction

	assign pend_map   = ipr & imr;
	// in-service sources also block lower ones
	assign active_map = (ipr | isr) & imr;
	assign hi_pend    = highest(pend_map);
	assign hi_active  = highest(active_map);

	// a higher source in service holds the line low
	assign irq_o = (pend_map != '0) && (hi_active == hi_pend);

	// acknowledge acts one cycle after iack rises
	assign ack_fire = iack_q1 && !iack_q2 && vec_valid_q;

	always_comb begin
		ipr_nxt = ipr;
		isr_nxt = isr;
		// acked source leaves pending and enters service with S set
		if (ack_fire) begin
			ipr_nxt[vec_q[3:0]] = 1'b0;
			if (vr[3])
				isr_nxt[vec_q[3:0]] = 1'b1;
		end
		// only enabled sources latch
		ipr_nxt = ipr_nxt | (event_i & ier);
		// enable and pending writes both clear zero bits
		if (ier_we_i[1] || ipr_we_i[1])
			ipr_nxt[15:8] = ipr_nxt[15:8] & din_i;
		if (ier_we_i[0] || ipr_we_i[0])
			ipr_nxt[7:0] = ipr_nxt[7:0] & din_i;
		if (isr_we_i[1])
			isr_nxt[15:8] = isr_nxt[15:8] & din_i;
		if (isr_we_i[0])
			isr_nxt[7:0] = isr_nxt[7:0] & din_i;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ier     <= '0;
			ipr     <= '0;
			isr     <= '0;
			imr     <= '0;
			vr      <= '0;
			iack_q1 <= 1'b0;
			iack_q2 <= 1'b0;
		end else begin
			ipr     <= ipr_nxt;
			isr     <= isr_nxt;
			iack_q1 <= iack_i;
			iack_q2 <= iack_q1;
			if (ier_we_i[1])
				ier[15:8] <= din_i;
			if (ier_we_i[0])
				ier[7:0] <= din_i;
			if (imr_we_i[1])
				imr[15:8] <= din_i;
			if (imr_we_i[0])
				imr[7:0] <= din_i;
			if (vr_we_i)
				vr <= din_i;
		end
	end

	// vector relatched every clock
	// pending clears late enough to keep it stable during iack
	always_ff @(posedge clk) begin
		vec_q       <= {vr[7:4], hi_pend};
		vec_valid_q <= (pend_map != '0);
	end

	assign ier_o    = ier;
	assign ipr_o    = ipr;
	assign isr_o    = isr;
	assign imr_o    = imr;
	assign vr_o     = vr;
	assign vector_o = vec_q;

	// no unmasked source above the requesting one may be in service
	a_irq_priority: assert property (@(posedge clk) disable iff (reset)
		irq_o |-> ((isr & imr) >> hi_pend) <= 16'd1)
		else $error("irq raised below a source in service");

endmodule

// File: mfp_timer.sv
// programmable 8-bit timer
`timescale 1ns/1ps
`include "mfp_settings.svh"

module mfp_timer #(
	parameter int HAS_EVENT = 1
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   xclk_i,
	input  mfp_pkg::mfp_tmr_ctrl_t ctrl_i,
	input  logic                   ctrl_we_i,
	input  mfp_pkg::mfp_byte_t     data_i,
	input  logic                   data_we_i,
	input  logic                   t_i,
	output mfp_pkg::mfp_tmr_ctrl_t ctrl_o,
	output mfp_pkg::mfp_byte_t     data_o,
	output logic                   pulse_mode_o,
	output logic                   done_o
);
	import mfp_pkg::*;

	mfp_tmr_ctrl_t ctrl_q;
	tmr_mode_e     mode;
	mfp_byte_t     reload;
	mfp_byte_t     counter;
	mfp_byte_t     presc_cnt;
	mfp_byte_t     presc_div;
	logic [2:0]    xclk_sync;
	logic [2:0]    t_sync;
	logic          xclk_edge;
	logic          presc_tick;
	logic          t_fall;
	logic          count_en;

	// mode from a control value
	// without event support bit 3 is ignored
	function automatic tmr_mode_e decode_mode(input mfp_tmr_ctrl_t c);
		if (HAS_EVENT != 0 && c[3])
			return (c[2:0] == 3'd0) ? TMR_EVENT : TMR_PULSE;
		else if (c[2:0] == 3'd0)
			return TMR_STOP;
		else
			return TMR_DELAY;
	endfunction

	// divisor for the low three control bits
	always_comb begin
		case (ctrl_q[2:0])
			3'd2:    presc_div = `MFP_PRESCALE_2;
			3'd3:    presc_div = `MFP_PRESCALE_3;
			3'd4:    presc_div = `MFP_PRESCALE_4;
			3'd5:    presc_div = `MFP_PRESCALE_5;
			3'd6:    presc_div = `MFP_PRESCALE_6;
			3'd7:    presc_div = `MFP_PRESCALE_7;
			default: presc_div = `MFP_PRESCALE_1;
		endcase
	end

	// sync external clock and timer input
	always_ff @(posedge clk) begin
		if (reset) begin
			xclk_sync <= '0;
			t_sync    <= '0;
		end else begin
			xclk_sync <= {xclk_sync[1:0], xclk_i};
			t_sync    <= {t_sync[1:0], t_i};
		end
	end

	// rising xclk edge drives the prescaler
	assign xclk_edge  = xclk_sync[1] & ~xclk_sync[2];
	assign presc_tick = xclk_edge && (presc_cnt >= presc_div - 8'd1);
	// active input edge is falling with aer already applied
	assign t_fall     = t_sync[2] & ~t_sync[1];

	// free running prescaler gives the first period a loose phase
	always_ff @(posedge clk) begin
		if (reset)
			presc_cnt <= '0;
		else if (xclk_edge)
			presc_cnt <= presc_tick ? 8'd0 : presc_cnt + 8'd1;
	end

	always_comb begin
		case (mode)
			TMR_DELAY: count_en = presc_tick;
			TMR_EVENT: count_en = (HAS_EVENT != 0) && t_fall;
			// pulse mode gates the ticks with the input level
			TMR_PULSE: count_en = (HAS_EVENT != 0) && presc_tick && t_sync[1];
			default:   count_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_q  <= '0;
			mode    <= TMR_STOP;
			reload  <= '0;
			counter <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (ctrl_we_i) begin
				ctrl_q <= ctrl_i;
				mode   <= decode_mode(ctrl_i);
			end
			if (data_we_i)
				reload <= data_i;
			// stopped timer takes the new value at once
			if (data_we_i && mode == TMR_STOP) begin
				counter <= data_i;
			end else if (count_en) begin
				// zero wraps to 255 first so 0 gives 256 counts
				if (counter == 8'd1) begin
					counter <= reload;
					done_o  <= 1'b1;
				end else begin
					counter <= counter - 8'd1;
				end
			end
		end
	end

	assign ctrl_o       = ctrl_q;
	assign data_o       = counter;
	assign pulse_mode_o = (mode == TMR_PULSE);

endmodule

// File: mfp_pkg.sv
// mfp shared types
package mfp_pkg;

	// cpu bus data and register contents
	typedef logic [7:0] mfp_byte_t;

	// register address on the cpu bus
	typedef logic [4:0] mfp_addr_t;

	// one bit per interrupt source
	typedef logic [15:0] mfp_irq_vec_t;

	// interrupt source number, also the vector low nibble
	typedef logic [3:0] mfp_irq_num_t;

	// timer control field
	// bit 3 picks event/pulse, bits 2..0 the prescaler
	typedef logic [4:0] mfp_tmr_ctrl_t;

	// timer operating mode
	typedef enum logic [1:0] {
		TMR_STOP,
		TMR_DELAY,
		TMR_EVENT,
		TMR_PULSE
	} tmr_mode_e;

endpackage

// File: mfp_settings.svh
// mfp register map and constants
`ifndef MFP_SETTINGS_SVH
`define MFP_SETTINGS_SVH

// cpu bus register addresses
`define MFP_A_GPIP   5'h00
`define MFP_A_AER    5'h01
`define MFP_A_DDR    5'h02
// interrupt registers, a is the upper half
`define MFP_A_IERA   5'h03
`define MFP_A_IERB   5'h04
`define MFP_A_IPRA   5'h05
`define MFP_A_IPRB   5'h06
`define MFP_A_ISRA   5'h07
`define MFP_A_ISRB   5'h08
`define MFP_A_IMRA   5'h09
`define MFP_A_IMRB   5'h0a
`define MFP_A_VR     5'h0b
// timer control and data
`define MFP_A_TACR   5'h0c
`define MFP_A_TBCR   5'h0d
`define MFP_A_TCDCR  5'h0e
`define MFP_A_TADR   5'h0f
`define MFP_A_TBDR   5'h10
`define MFP_A_TCDR   5'h11
`define MFP_A_TDDR   5'h12
// uart transmit status and data
`define MFP_A_TSR    5'h16
`define MFP_A_UDR    5'h17

// tx fifo holds 2^bits slots, one kept free
`define MFP_FIFO_ADDR_BITS 4

// prescaler divisors for control values 1..7
`define MFP_PRESCALE_1 8'd4
`define MFP_PRESCALE_2 8'd10
`define MFP_PRESCALE_3 8'd16
`define MFP_PRESCALE_4 8'd50
`define MFP_PRESCALE_5 8'd64
`define MFP_PRESCALE_6 8'd100
`define MFP_PRESCALE_7 8'd200

// interrupt source numbers
`define MFP_IRQ_TA  4'd13
`define MFP_IRQ_TB  4'd8
`define MFP_IRQ_TC  4'd5
`define MFP_IRQ_TD  4'd4
`define MFP_IRQ_GP3 4'd3
`define MFP_IRQ_GP4 4'd6
`define MFP_IRQ_GP5 4'd7
`define MFP_IRQ_GP7 4'd15

`endif
